// ==== net_pkg.sv ====
`default_nettype none

package net_pkg;

    // one IPv4 address, most significant octet first
    typedef logic [31:0] ip_addr_t;

    typedef logic [15:0] udp_port_t;

    // parsed UDP datagram header, same layout for rx and reply
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        logic [15:0] length;
    } udp_hdr_t;

    // one payload byte on the stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } pay_beat_t;

    // active-low segments, bit 0 is segment a
    typedef logic [6:0] seg7_t;

    // digit k shows nibble k of the peer address
    typedef seg7_t [7:0] hex_bank_t;

    localparam int LED_WIDTH = 18;

endpackage

`default_nettype wire

// ==== echo_cfg_pkg.sv ====
`default_nettype none

package echo_cfg_pkg;

    // source address of every reply, 192.168.50.168
    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd50, 8'd168};

    // the only port that gets an answer
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    // reply headers waiting for the tx side
    localparam int HDR_FIFO_DEPTH = 4;

    // payload bytes waiting for the tx side
    localparam int PAY_FIFO_DEPTH = 64;

endpackage

`default_nettype wire

// ==== stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  wire  i_clk,
    input  wire  i_rst,
    input  wire  i_push_valid,
    output logic o_push_ready,
    input  wire  T i_push,
    output logic o_pop_valid,
    input  wire  i_pop_ready,
    output T     o_pop
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_fire;
    logic             pop_fire;

    assign o_push_ready = (count != CNT_W'(DEPTH));
    assign o_pop_valid  = (count != '0);
    assign o_pop        = mem[rd_ptr];

    assign push_fire = i_push_valid && o_push_ready;
    assign pop_fire  = o_pop_valid && i_pop_ready;

    // item storage
    always_ff @(posedge i_clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= i_push;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (push_fire && !pop_fire) begin
                count <= count + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge i_clk) disable iff (i_rst)
        count <= CNT_W'(DEPTH));

    // an empty buffer has both pointers on the same slot
    a_no_empty_pop: assert property (@(posedge i_clk) disable iff (i_rst)
        (count == '0) |-> (rd_ptr == wr_ptr));

endmodule

`default_nettype wire

// ==== echo_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module echo_ctrl
    import net_pkg::*;
    import echo_cfg_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst,

    input  wire       i_rx_hdr_valid,
    output logic      o_rx_hdr_ready,
    input  wire       udp_hdr_t i_rx_hdr,

    input  wire       i_rx_pay_valid,
    output logic      o_rx_pay_ready,
    input  wire       pay_beat_t i_rx_pay,

    output logic      o_hdr_push_valid,
    input  wire       i_hdr_push_ready,
    output udp_hdr_t  o_hdr_push,

    output logic      o_pay_push_valid,
    input  wire       i_pay_push_ready,
    output pay_beat_t o_pay_push
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_FORWARD = 2'd1,
        ST_DISCARD = 2'd2
    } state_t;

    state_t state;

    logic port_match;
    logic hdr_fire;
    logic pay_fire;

    assign port_match = (i_rx_hdr.dst_port == ECHO_PORT);

    // matching frames need room for the reply, others are simply dropped
    assign o_rx_hdr_ready = (state == ST_IDLE) && (!port_match || i_hdr_push_ready);
    assign hdr_fire       = i_rx_hdr_valid && o_rx_hdr_ready;

    // reply goes into the header FIFO on the accepting edge
    assign o_hdr_push_valid = i_rx_hdr_valid && (state == ST_IDLE) && port_match;

    always_comb begin
        o_hdr_push          = i_rx_hdr;
        o_hdr_push.src_ip   = LOCAL_IP;
        o_hdr_push.dst_ip   = i_rx_hdr.src_ip;
        o_hdr_push.src_port = i_rx_hdr.dst_port;
        o_hdr_push.dst_port = i_rx_hdr.src_port;
    end

    // echoed bytes wait on FIFO space, discarded bytes sink freely
    assign o_rx_pay_ready = ((state == ST_FORWARD) && i_pay_push_ready) ||
                            (state == ST_DISCARD);
    assign pay_fire       = i_rx_pay_valid && o_rx_pay_ready;

    assign o_pay_push_valid = i_rx_pay_valid && (state == ST_FORWARD);
    assign o_pay_push       = i_rx_pay;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_fire) begin
                        state <= port_match ? ST_FORWARD : ST_DISCARD;
                    end
                end
                ST_FORWARD, ST_DISCARD: begin
                    if (pay_fire && i_rx_pay.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // upstream must hold a stalled header
    a_hdr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_rx_hdr_valid && !o_rx_hdr_ready) |=> (i_rx_hdr_valid && $stable(i_rx_hdr)));

    // the frame closes with its last beat, so nothing follows until the next header
    a_no_idle_push: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_pay_push_valid && i_pay_push_ready && o_pay_push.last) |=> !o_pay_push_valid);

endmodule

`default_nettype wire

// ==== status_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_display
    import net_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_tx_hdr_valid,
    input  wire                  i_tx_hdr_ready,
    input  wire ip_addr_t        i_tx_hdr_dst_ip,
    input  wire                  i_tx_pay_valid,
    input  wire                  i_tx_pay_ready,
    input  wire pay_beat_t       i_tx_pay,
    output logic [LED_WIDTH-1:0] o_led_r,
    output hex_bank_t            o_hex
);

    // active-low glyphs, segment order gfedcba
    function automatic seg7_t hex_to_seg(input logic [3:0] nib);
        seg7_t seg;
        case (nib)
            4'h0: seg = 7'h40;
            4'h1: seg = 7'h79;
            4'h2: seg = 7'h24;
            4'h3: seg = 7'h30;
            4'h4: seg = 7'h19;
            4'h5: seg = 7'h12;
            4'h6: seg = 7'h02;
            4'h7: seg = 7'h78;
            4'h8: seg = 7'h00;
            4'h9: seg = 7'h10;
            4'ha: seg = 7'h08;
            4'hb: seg = 7'h03;
            4'hc: seg = 7'h46;
            4'hd: seg = 7'h21;
            4'he: seg = 7'h06;
            default: seg = 7'h0e;
        endcase
        return seg;
    endfunction

    logic     frame_start;
    ip_addr_t peer_ip;

    // first byte after reset or after a last beat opens a frame
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            frame_start <= 1'b1;
            o_led_r     <= '0;
        end else if (i_tx_pay_valid && i_tx_pay_ready) begin
            if (frame_start) begin
                o_led_r <= {{(LED_WIDTH - 8){1'b0}}, i_tx_pay.data};
            end
            frame_start <= i_tx_pay.last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            peer_ip <= '0;
        end else if (i_tx_hdr_valid && i_tx_hdr_ready) begin
            peer_ip <= i_tx_hdr_dst_ip;
        end
    end

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            o_hex[k] = hex_to_seg(peer_ip[4*k +: 4]);
        end
    end

endmodule

`default_nettype wire

// ==== udp_echo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_echo_top
    import net_pkg::*;
    import echo_cfg_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,

    input  wire                  i_rx_hdr_valid,
    output logic                 o_rx_hdr_ready,
    input  wire udp_hdr_t        i_rx_hdr,
    input  wire                  i_rx_pay_valid,
    output logic                 o_rx_pay_ready,
    input  wire pay_beat_t       i_rx_pay,

    output logic                 o_tx_hdr_valid,
    input  wire                  i_tx_hdr_ready,
    output udp_hdr_t             o_tx_hdr,
    output logic                 o_tx_pay_valid,
    input  wire                  i_tx_pay_ready,
    output pay_beat_t            o_tx_pay,

    output logic [LED_WIDTH-1:0] o_led_r,
    output hex_bank_t            o_hex
);

    // control to FIFO push side
    logic      hdr_push_valid;
    logic      hdr_push_ready;
    udp_hdr_t  hdr_push;
    logic      pay_push_valid;
    logic      pay_push_ready;
    pay_beat_t pay_push;

    echo_ctrl u_echo_ctrl (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_rx_hdr_valid   (i_rx_hdr_valid),
        .o_rx_hdr_ready   (o_rx_hdr_ready),
        .i_rx_hdr         (i_rx_hdr),
        .i_rx_pay_valid   (i_rx_pay_valid),
        .o_rx_pay_ready   (o_rx_pay_ready),
        .i_rx_pay         (i_rx_pay),
        .o_hdr_push_valid (hdr_push_valid),
        .i_hdr_push_ready (hdr_push_ready),
        .o_hdr_push       (hdr_push),
        .o_pay_push_valid (pay_push_valid),
        .i_pay_push_ready (pay_push_ready),
        .o_pay_push       (pay_push)
    );

    stream_fifo #(.T(udp_hdr_t), .DEPTH(HDR_FIFO_DEPTH)) hdr_fifo (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_push_valid (hdr_push_valid),
        .o_push_ready (hdr_push_ready),
        .i_push       (hdr_push),
        .o_pop_valid  (o_tx_hdr_valid),
        .i_pop_ready  (i_tx_hdr_ready),
        .o_pop        (o_tx_hdr)
    );

    stream_fifo #(.T(pay_beat_t), .DEPTH(PAY_FIFO_DEPTH)) pay_fifo (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_push_valid (pay_push_valid),
        .o_push_ready (pay_push_ready),
        .i_push       (pay_push),
        .o_pop_valid  (o_tx_pay_valid),
        .i_pop_ready  (i_tx_pay_ready),
        .o_pop        (o_tx_pay)
    );

    // display watches the tx handshakes only
    status_display u_status_display (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_tx_hdr_valid  (o_tx_hdr_valid),
        .i_tx_hdr_ready  (i_tx_hdr_ready),
        .i_tx_hdr_dst_ip (o_tx_hdr.dst_ip),
        .i_tx_pay_valid  (o_tx_pay_valid),
        .i_tx_pay_ready  (i_tx_pay_ready),
        .i_tx_pay        (o_tx_pay),
        .o_led_r         (o_led_r),
        .o_hex           (o_hex)
    );

endmodule

`default_nettype wire

// ==== tb_udp_echo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_udp_echo
    import net_pkg::*;
    import echo_cfg_pkg::*;
();

    localparam int NUM_FRAMES = 200;
    // up to 16 beats plus header and gaps per frame times 4 for tx stalls
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (16 + 4) * 4;

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_rx_hdr_valid;
    logic                 o_rx_hdr_ready;
    udp_hdr_t             i_rx_hdr;
    logic                 i_rx_pay_valid;
    logic                 o_rx_pay_ready;
    pay_beat_t            i_rx_pay;
    logic                 o_tx_hdr_valid;
    logic                 i_tx_hdr_ready;
    udp_hdr_t             o_tx_hdr;
    logic                 o_tx_pay_valid;
    logic                 i_tx_pay_ready;
    pay_beat_t            o_tx_pay;
    logic [LED_WIDTH-1:0] o_led_r;
    hex_bank_t            o_hex;

    // reference model state
    udp_hdr_t             hdr_q[$];
    pay_beat_t            pay_q[$];
    logic [LED_WIDTH-1:0] exp_led;
    ip_addr_t             exp_peer;
    logic                 tx_first;
    logic                 rx_echo;
    logic                 run_checks;

    int hdr_errs;
    int pay_errs;
    int disp_errs;
    int misc_errs;
    int cycle_count;
    int echo_frames;

    udp_echo_top DUT (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_rx_hdr_valid (i_rx_hdr_valid),
        .o_rx_hdr_ready (o_rx_hdr_ready),
        .i_rx_hdr       (i_rx_hdr),
        .i_rx_pay_valid (i_rx_pay_valid),
        .o_rx_pay_ready (o_rx_pay_ready),
        .i_rx_pay       (i_rx_pay),
        .o_tx_hdr_valid (o_tx_hdr_valid),
        .i_tx_hdr_ready (i_tx_hdr_ready),
        .o_tx_hdr       (o_tx_hdr),
        .o_tx_pay_valid (o_tx_pay_valid),
        .i_tx_pay_ready (i_tx_pay_ready),
        .o_tx_pay       (o_tx_pay),
        .o_led_r        (o_led_r),
        .o_hex          (o_hex)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // standard active-low glyphs with bit 0 as segment a
    function automatic seg7_t expected_glyph(input logic [3:0] nib);
        seg7_t glyphs [16];
        glyphs = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                   7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
        return glyphs[nib];
    endfunction

    // reply goes back to the sender from the local address with ports swapped
    function automatic udp_hdr_t reply_for(input udp_hdr_t req);
        udp_hdr_t rep;
        rep.src_ip   = LOCAL_IP;
        rep.dst_ip   = req.src_ip;
        rep.src_port = req.dst_port;
        rep.dst_port = req.src_port;
        rep.length   = req.length;
        return rep;
    endfunction

    task automatic send_header(input udp_hdr_t hdr);
        i_rx_hdr_valid <= 1'b1;
        i_rx_hdr       <= hdr;
        do begin
            @(posedge i_clk);
        end while (!o_rx_hdr_ready);
        i_rx_hdr_valid <= 1'b0;
    endtask

    task automatic send_beat(input pay_beat_t beat);
        i_rx_pay_valid <= 1'b1;
        i_rx_pay       <= beat;
        do begin
            @(posedge i_clk);
        end while (!o_rx_pay_ready);
    endtask

    task automatic check_reply_header();
        udp_hdr_t want;
        assert (hdr_q.size() != 0) else begin
            hdr_errs++;
            $display("%0t: reply header sent although no echoed frame is pending", $time);
        end
        if (hdr_q.size() != 0) begin
            want = hdr_q.pop_front();
            assert (o_tx_hdr == want) else begin
                hdr_errs++;
                $display("[FAIL] %0t o_tx_hdr exp=%h got=%h", $time, want, o_tx_hdr);
            end
            exp_peer = want.dst_ip;
        end
    endtask

    task automatic check_reply_byte();
        pay_beat_t want;
        assert (pay_q.size() != 0) else begin
            pay_errs++;
            $display("%0t: reply byte sent although no echoed byte is pending", $time);
        end
        if (pay_q.size() != 0) begin
            want = pay_q.pop_front();
            assert (o_tx_pay == want) else begin
                pay_errs++;
                $display("[FAIL] %0t o_tx_pay exp=%h got=%h", $time, want, o_tx_pay);
            end
            if (tx_first) begin
                exp_led = LED_WIDTH'(want.data);
            end
            tx_first = want.last;
        end
    endtask

    task automatic check_reset_state();
        @(negedge i_clk);
        assert (!o_tx_hdr_valid && !o_tx_pay_valid) else begin
            misc_errs++;
            $display("%0t: a transmit valid is high right after reset", $time);
        end
        assert (o_rx_hdr_ready && !o_rx_pay_ready) else begin
            misc_errs++;
            $display("%0t: receive ready levels are wrong right after reset", $time);
        end
        assert (o_led_r == '0) else begin
            misc_errs++;
            $display("[FAIL] %0t o_led_r exp=%h got=%h", $time, {LED_WIDTH{1'b0}}, o_led_r);
        end
        for (int k = 0; k < 8; k++) begin
            assert (o_hex[k] == expected_glyph(4'h0)) else begin
                misc_errs++;
                $display("[FAIL] %0t o_hex[%0d] exp=%h got=%h", $time, k,
                         expected_glyph(4'h0), o_hex[k]);
            end
        end
    endtask

    // scoreboard pops tx before pushing rx on the same edge
    always @(posedge i_clk) begin
        if (i_rst) begin
            exp_led  = '0;
            exp_peer = '0;
            tx_first = 1'b1;
            rx_echo  = 1'b0;
            hdr_q.delete();
            pay_q.delete();
        end else begin
            if (o_tx_hdr_valid && i_tx_hdr_ready) begin
                check_reply_header();
            end
            if (o_tx_pay_valid && i_tx_pay_ready) begin
                check_reply_byte();
            end
            if (i_rx_pay_valid && o_rx_pay_ready && rx_echo) begin
                pay_q.push_back(i_rx_pay);
            end
            if (i_rx_hdr_valid && o_rx_hdr_ready) begin
                rx_echo = (i_rx_hdr.dst_port == ECHO_PORT);
                if (rx_echo) begin
                    hdr_q.push_back(reply_for(i_rx_hdr));
                    echo_frames++;
                end
            end
        end
    end

    // display registers settle on the edge and are compared half a cycle later
    always @(negedge i_clk) begin
        if (run_checks) begin
            assert (o_led_r == exp_led) else begin
                disp_errs++;
                $display("[FAIL] %0t o_led_r exp=%h got=%h", $time, exp_led, o_led_r);
            end
            for (int k = 0; k < 8; k++) begin
                assert (o_hex[k] == expected_glyph(exp_peer[4*k +: 4])) else begin
                    disp_errs++;
                    $display("[FAIL] %0t o_hex[%0d] exp=%h got=%h", $time, k,
                             expected_glyph(exp_peer[4*k +: 4]), o_hex[k]);
                end
            end
        end
    end

    // tx back-pressure with ready low about 30% of cycles
    initial begin
        i_tx_hdr_ready <= 1'b0;
        i_tx_pay_ready <= 1'b0;
        forever begin
            @(posedge i_clk);
            i_tx_hdr_ready <= (($urandom() % 10) >= 3);
            i_tx_pay_ready <= (($urandom() % 10) >= 3);
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d headers and %0d bytes never came back",
                 cycle_count, hdr_q.size(), pay_q.size());
        $display("TB FAILED");
        $finish;
    end

    initial begin
        udp_hdr_t  hdr;
        pay_beat_t beat;
        udp_port_t port;
        int        len;
        int        gap;
        int        total;
        i_rst          <= 1'b1;
        i_rx_hdr_valid <= 1'b0;
        i_rx_hdr       <= '0;
        i_rx_pay_valid <= 1'b0;
        i_rx_pay       <= '0;
        run_checks = 1'b0;
        void'($urandom(32'h5e4c_e21a));
        repeat (10) @(posedge i_clk);
        i_rst <= 1'b0;
        check_reset_state();
        run_checks = 1'b1;
        @(posedge i_clk);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            gap = int'($urandom() % 4);
            repeat (gap) @(posedge i_clk);
            len = 1 + int'($urandom() % 16);
            hdr.src_ip   = $urandom();
            hdr.dst_ip   = $urandom();
            hdr.src_port = 16'($urandom());
            hdr.length   = 16'(len);
            // half of the frames go to the echo port
            if (($urandom() % 2) == 0) begin
                hdr.dst_port = ECHO_PORT;
            end else begin
                port = 16'($urandom());
                if (port == ECHO_PORT) begin
                    port = port + 16'd1;
                end
                hdr.dst_port = port;
            end
            send_header(hdr);
            for (int b = 0; b < len; b++) begin
                if (($urandom() % 5) == 0) begin
                    i_rx_pay_valid <= 1'b0;
                    @(posedge i_clk);
                end
                beat.data = 8'($urandom());
                beat.last = (b == len - 1);
                send_beat(beat);
            end
            i_rx_pay_valid <= 1'b0;
        end

        // let the last transfers land and wait for both FIFOs to drain
        repeat (2) @(posedge i_clk);
        while (o_tx_hdr_valid || o_tx_pay_valid) begin
            @(posedge i_clk);
        end
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        assert (!o_tx_hdr_valid && !o_tx_pay_valid) else begin
            misc_errs++;
            $display("%0t: extra reply data left in the DUT after the last frame", $time);
        end
        assert (hdr_q.size() == 0 && pay_q.size() == 0) else begin
            misc_errs++;
            $display("%0t: expected replies still pending at the end", $time);
        end

        $display("echoed %0d of %0d frames", echo_frames, NUM_FRAMES);
        total = hdr_errs + pay_errs + disp_errs + misc_errs;
        $display("errors: header %0d, payload %0d, display %0d, other %0d",
                 hdr_errs, pay_errs, disp_errs, misc_errs);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
net_pkg.sv
echo_cfg_pkg.sv
stream_fifo.sv
echo_ctrl.sv
status_display.sv
udp_echo_top.sv
tb_udp_echo.sv

// ==== Makefile ====
TOP = tb_udp_echo

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TB FAILED" sim.log; then \
		echo "sim: failure reported"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" sim.log; then \
		echo "sim: run ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
